//--- hw/cw_io_pkg.sv
`default_nettype none

package cw_io_pkg;

	typedef logic [5:0]  reg_addr_t; // register address on the access port
	typedef logic [7:0]  reg_byte_t; // one data byte
	typedef logic [15:0] byte_cnt_t; // byte counter within a multi-byte access
	typedef logic [2:0]  reg_sel_t;  // decoded register select

	localparam int NUM_PINS = 4; // target gpio pins, fixed by routing layout
	localparam int USI_PINS = 3; // pins 1 to 3 can carry usi
	localparam int OC_PIN   = 2; // pin 3 has the open-collector options

	typedef logic [NUM_PINS-1:0] pin_vec_t; // one bit per target pin
	typedef logic [5:0]          trig_src_t; // fpa, nrst, io1..io4
	typedef logic [3:0]          trig_mod_t; // advio, anapattern, decodedio, anaedge

	localparam reg_sel_t SEL_NONE    = 3'd0; // nothing readable addressed
	localparam reg_sel_t SEL_TRIGSRC = 3'd1;
	localparam reg_sel_t SEL_TRIGMOD = 3'd2;
	localparam reg_sel_t SEL_IOROUTE = 3'd3;
	localparam reg_sel_t SEL_IOREAD  = 3'd4;

	localparam reg_addr_t ADDR_TRIGSRC = 6'd39;
	localparam reg_addr_t ADDR_TRIGMOD = 6'd40;
	localparam reg_addr_t ADDR_IOROUTE = 6'd55;
	localparam reg_addr_t ADDR_IOREAD  = 6'd59; // read only

	localparam reg_byte_t RST_TRIGSRC = 8'h01; // front panel on, or mode
	localparam reg_byte_t RST_TRIGMOD = 8'h00;
	localparam reg_byte_t RST_ROUTE0  = 8'h01; // pin 1 drives uart tx
	localparam reg_byte_t RST_ROUTE1  = 8'h02; // pin 2 feeds uart rx

	// bit positions inside a pin routing byte
	localparam int RT_TX   = 0;
	localparam int RT_RX   = 1;
	localparam int RT_USIO = 2;
	localparam int RT_USII = 3;
	localparam int RT_USOC = 4; // usi out, open collector (pin 3)
	localparam int RT_TXOC = 5; // uart tx, open collector (pin 3)
	localparam int RT_GPV  = 6;
	localparam int RT_GPE  = 7;

	localparam int BYTE_EXTRA  = 5; // avrprog and power control
	localparam int BYTE_PINCTL = 6; // nrst/pdid/pdic enable and value pairs
	localparam int EX_AVRPROG  = 0;
	localparam int EX_PWROFF   = 1;

	localparam int TS_MODE_LSB = 6; // trigsrc combine mode in [7:6]
	localparam int TM_FPA_OE   = 3; // trigmod front panel drive enable

endpackage

`default_nettype wire

//--- hw/cw_config_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cw_config_if #(
	parameter int ROUTE_BYTES = 8
);
	import cw_io_pkg::*;

	reg_byte_t trigsrc;                  // trigger source enables and mode
	reg_byte_t trigmod;                  // trigger module select and fpa drive
	reg_byte_t route [ROUTE_BYTES];      // pin routing, glitch, extra, pinctl
	logic      power_off_req;            // stored power-off bit ahead of its output register

	modport bank (
		output trigsrc, trigmod, route, power_off_req
	);

	modport user (
		input trigsrc, trigmod, route, power_off_req
	);

endinterface

`default_nettype wire

//--- hw/reg_access_decode.sv
`timescale 1ns/1ns
`default_nettype none

module reg_access_decode #(
	parameter int ROUTE_BYTES = 8
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire  cw_io_pkg::reg_addr_t    reg_addr_i,
	input  wire  cw_io_pkg::byte_cnt_t    reg_bytecnt_i,
	input  wire  cw_io_pkg::reg_byte_t    reg_datai_i,
	input  wire                           reg_read_i,
	input  wire                           reg_write_i,
	input  wire                           reg_addrvalid_i,
	cw_config_if.bank                     cfg,
	output cw_io_pkg::reg_sel_t           rd_sel_o,
	output logic                          rd_en_o,
	output logic [$clog2(ROUTE_BYTES)-1:0] rd_byte_o
);
	import cw_io_pkg::*;

	localparam int IDX_W = $clog2(ROUTE_BYTES);

	reg_sel_t  sel;                      // one decode shared by write and read
	logic      route_in_range;           // byte count points inside the bank
	reg_byte_t trigsrc_q;
	reg_byte_t trigmod_q;
	reg_byte_t route_q [ROUTE_BYTES];

	always_comb begin
		sel = SEL_NONE;
		if (reg_addrvalid_i) begin
			case (reg_addr_i)
				ADDR_TRIGSRC: sel = SEL_TRIGSRC;
				ADDR_TRIGMOD: sel = SEL_TRIGMOD;
				ADDR_IOROUTE: sel = SEL_IOROUTE;
				ADDR_IOREAD:  sel = SEL_IOREAD;
				default:      sel = SEL_NONE; // unmapped address
			endcase
		end
	end

	assign route_in_range = (reg_bytecnt_i < byte_cnt_t'(ROUTE_BYTES));

	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= RST_TRIGSRC;
			trigmod_q <= RST_TRIGMOD;
			for (int i = 0; i < ROUTE_BYTES; i++) begin
				route_q[i] <= '0;
			end
			route_q[0] <= RST_ROUTE0; // uart tx on pin 1
			route_q[1] <= RST_ROUTE1; // uart rx from pin 2
		end else if (reg_write_i) begin
			case (sel)
				SEL_TRIGSRC: trigsrc_q <= reg_datai_i;
				SEL_TRIGMOD: trigmod_q <= reg_datai_i;
				SEL_IOROUTE: begin
					if (route_in_range) begin
						route_q[reg_bytecnt_i[IDX_W-1:0]] <= reg_datai_i;
					end
				end
				default: ; // ioread and unknown writes dropped
			endcase
		end
	end

	assign cfg.trigsrc       = trigsrc_q;
	assign cfg.trigmod       = trigmod_q;
	assign cfg.route         = route_q;
	assign cfg.power_off_req = route_q[BYTE_EXTRA][EX_PWROFF];

	assign rd_sel_o  = sel;
	assign rd_en_o   = reg_read_i;
	assign rd_byte_o = reg_bytecnt_i[IDX_W-1:0]; // low bits pick the routing byte

endmodule

`default_nettype wire

//--- hw/trigger_combine.sv
`timescale 1ns/1ns
`default_nettype none

module trigger_combine (
	cw_config_if.user              cfg,
	input  wire cw_io_pkg::trig_src_t trig_in_i,     // fpa, nrst, io1..io4
	input  wire cw_io_pkg::trig_mod_t trig_module_i, // advio, anapat, decio, anaedge
	output logic                   trig_ext_o,
	output logic                   trig_o,
	output logic                   trig_fpa_oe_o
);
	import cw_io_pkg::*;

	trig_src_t src_en;                   // per-source enable from trigsrc
	logic      trig_or;
	logic      trig_and;

	assign src_en = cfg.trigsrc[5:0];

	assign trig_or  = |(trig_in_i & src_en);  // any enabled source high
	assign trig_and = &(trig_in_i | ~src_en); // disabled sources count as true

	always_comb begin
		case (cfg.trigsrc[TS_MODE_LSB +: 2])
			2'b00:   trig_ext_o = trig_or;
			2'b01:   trig_ext_o = trig_and;
			2'b10:   trig_ext_o = ~trig_and; // nand
			default: trig_ext_o = 1'b0;      // mode 3 holds trigger off
		endcase
	end

	always_comb begin
		case (cfg.trigmod[2:0])
			3'd0:    trig_o = trig_ext_o;       // plain edge trigger
			3'd1:    trig_o = trig_module_i[0]; // advanced io pattern
			3'd2:    trig_o = trig_module_i[1]; // analog pattern
			3'd3:    trig_o = trig_module_i[2]; // decoded io
			3'd4:    trig_o = trig_module_i[3]; // analog edge
			default: trig_o = 1'b0;             // codes 5..7 unused
		endcase
	end

	// front panel pin driven with the trigger when bit 3 set
	assign trig_fpa_oe_o = cfg.trigmod[TM_FPA_OE];

endmodule

`default_nettype wire

//--- hw/target_io_route.sv
`timescale 1ns/1ns
`default_nettype none

module target_io_route (
	input  wire                      clk,
	input  wire                      reset,
	cw_config_if.user                cfg,
	input  wire  cw_io_pkg::pin_vec_t pin_in_i,
	output cw_io_pkg::pin_vec_t      pin_o,
	output cw_io_pkg::pin_vec_t      pin_oe_o,
	input  wire                      uart_tx_i,
	input  wire                      usi_out_i,
	output logic                     uart_rx_o,
	output logic                     usi_in_o,
	output logic                     targetpower_off_o,
	output logic                     avrprog_en_o,
	output logic [2:0]               pin_ctrl_en_o, // nrst, pdid, pdic
	output logic [2:0]               pin_ctrl_o,
	output cw_io_pkg::pin_vec_t      pin_sample_o
);
	import cw_io_pkg::*;

	logic     power_off_q;               // registered copy of the power bit
	pin_vec_t pin_sample_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			power_off_q  <= 1'b0;
			pin_sample_q <= '0;
		end else begin
			power_off_q  <= cfg.power_off_req;
			pin_sample_q <= pin_in_i; // one clock behind the pads
		end
	end

	always_comb begin : drive_pins
		reg_byte_t rt;
		for (int p = 0; p < NUM_PINS; p++) begin
			rt = cfg.route[p];
			pin_o[p]    = 1'b0;
			pin_oe_o[p] = 1'b0;
			if (rt[RT_TX]) begin
				pin_o[p]    = uart_tx_i;
				pin_oe_o[p] = 1'b1;
			end else if (p < USI_PINS && rt[RT_USIO]) begin
				pin_o[p]    = usi_out_i;
				pin_oe_o[p] = 1'b1;
			end else if (p == OC_PIN && rt[RT_USOC]) begin
				pin_oe_o[p] = ~usi_out_i; // pulls low only and floats for 1
			end else if (p == OC_PIN && rt[RT_TXOC]) begin
				pin_oe_o[p] = ~uart_tx_i;
			end else if (rt[RT_GPE]) begin
				pin_o[p]    = rt[RT_GPV]; // static gpio level
				pin_oe_o[p] = 1'b1;
			end
			if (power_off_q) begin
				pin_oe_o[p] = 1'b0; // unpowered target keeps every pin high-z
			end
		end
	end

	// scan downwards so the lowest marked pin wins
	always_comb begin
		uart_rx_o = 1'b1; // idle line when nothing routed
		for (int p = NUM_PINS - 1; p >= 0; p--) begin
			if (cfg.route[p][RT_RX]) begin
				uart_rx_o = pin_in_i[p];
			end
		end
	end

	always_comb begin
		usi_in_o = 1'b1;
		for (int p = USI_PINS - 1; p >= 0; p--) begin
			if (cfg.route[p][RT_USII]) begin
				usi_in_o = pin_in_i[p];
			end
		end
	end

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			pin_ctrl_en_o[k] = cfg.route[BYTE_PINCTL][2*k];   // enable bit of pair
			pin_ctrl_o[k]    = cfg.route[BYTE_PINCTL][2*k+1]; // value bit of pair
		end
	end

	assign avrprog_en_o      = cfg.route[BYTE_EXTRA][EX_AVRPROG];
	assign targetpower_off_o = power_off_q;
	assign pin_sample_o      = pin_sample_q;

endmodule

`default_nettype wire

//--- hw/reg_readback.sv
`timescale 1ns/1ns
`default_nettype none

module reg_readback #(
	parameter int ROUTE_BYTES = 8
) (
	input  wire                             clk,
	input  wire                             reset,
	cw_config_if.user                       cfg,
	input  wire  cw_io_pkg::reg_sel_t       rd_sel_i,
	input  wire                             rd_en_i,
	input  wire  [$clog2(ROUTE_BYTES)-1:0]  rd_byte_i,
	input  wire  cw_io_pkg::pin_vec_t       pin_sample_i,
	output cw_io_pkg::reg_byte_t            reg_datao_o
);
	import cw_io_pkg::*;

	reg_byte_t rd_data_q;                // captured on the read strobe
	logic      rd_valid_q;               // last cycle addressed a readable register

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= (rd_sel_i != SEL_NONE); // select already masked by addrvalid
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			case (rd_sel_i)
				SEL_TRIGSRC: rd_data_q <= cfg.trigsrc;
				SEL_TRIGMOD: rd_data_q <= cfg.trigmod;
				SEL_IOROUTE: begin
					if (int'(rd_byte_i) < ROUTE_BYTES) begin
						rd_data_q <= cfg.route[rd_byte_i];
					end else begin
						rd_data_q <= '0;
					end
				end
				SEL_IOREAD:  rd_data_q <= reg_byte_t'(pin_sample_i); // upper nibble zero
				default:     rd_data_q <= '0;
			endcase
		end
	end

	// shared read bus sees zero from here unless addressed
	assign reg_datao_o = rd_valid_q ? rd_data_q : '0;

endmodule

`default_nettype wire

//--- hw/cw_io_top.sv
`timescale 1ns/1ns
`default_nettype none

module cw_io_top #(
	parameter int ROUTE_BYTES = 8 // number of routing bytes (7 or 8)
) (
	input  wire                       clk,
	input  wire                       reset,
	// register access port
	input  wire  cw_io_pkg::reg_addr_t reg_addr_i,
	input  wire  cw_io_pkg::byte_cnt_t reg_bytecnt_i,
	input  wire  cw_io_pkg::reg_byte_t reg_datai_i,
	output cw_io_pkg::reg_byte_t      reg_datao_o,
	input  wire                       reg_read_i,
	input  wire                       reg_write_i,
	input  wire                       reg_addrvalid_i,
	// triggers
	input  wire  cw_io_pkg::trig_src_t trig_in_i,
	input  wire  cw_io_pkg::trig_mod_t trig_module_i,
	output logic                      trig_ext_o,
	output logic                      trig_o,
	output logic                      trig_fpa_oe_o,
	// target pins
	input  wire  cw_io_pkg::pin_vec_t pin_in_i,
	output cw_io_pkg::pin_vec_t       pin_o,
	output cw_io_pkg::pin_vec_t       pin_oe_o,
	input  wire                       uart_tx_i,
	input  wire                       usi_out_i,
	output logic                      uart_rx_o,
	output logic                      usi_in_o,
	output logic                      targetpower_off_o,
	output logic                      avrprog_en_o,
	output logic [2:0]                pin_ctrl_en_o,
	output logic [2:0]                pin_ctrl_o
);
	import cw_io_pkg::*;

	localparam int IDX_W = $clog2(ROUTE_BYTES);

	reg_sel_t   rd_sel;                  // decode -> readback
	logic       rd_en;
	logic [IDX_W-1:0] rd_byte;
	pin_vec_t   pin_sample;              // route -> readback

	cw_config_if #(.ROUTE_BYTES(ROUTE_BYTES)) cfg_if ();

	reg_access_decode #(.ROUTE_BYTES(ROUTE_BYTES)) u_decode (
		.clk             (clk),
		.reset           (reset),
		.reg_addr_i      (reg_addr_i),
		.reg_bytecnt_i   (reg_bytecnt_i),
		.reg_datai_i     (reg_datai_i),
		.reg_read_i      (reg_read_i),
		.reg_write_i     (reg_write_i),
		.reg_addrvalid_i (reg_addrvalid_i),
		.cfg             (cfg_if.bank),
		.rd_sel_o        (rd_sel),
		.rd_en_o         (rd_en),
		.rd_byte_o       (rd_byte)
	);

	trigger_combine u_trig (
		.cfg           (cfg_if.user),
		.trig_in_i     (trig_in_i),
		.trig_module_i (trig_module_i),
		.trig_ext_o    (trig_ext_o),
		.trig_o        (trig_o),
		.trig_fpa_oe_o (trig_fpa_oe_o)
	);

	target_io_route u_route (
		.clk               (clk),
		.reset             (reset),
		.cfg               (cfg_if.user),
		.pin_in_i          (pin_in_i),
		.pin_o             (pin_o),
		.pin_oe_o          (pin_oe_o),
		.uart_tx_i         (uart_tx_i),
		.usi_out_i         (usi_out_i),
		.uart_rx_o         (uart_rx_o),
		.usi_in_o          (usi_in_o),
		.targetpower_off_o (targetpower_off_o),
		.avrprog_en_o      (avrprog_en_o),
		.pin_ctrl_en_o     (pin_ctrl_en_o),
		.pin_ctrl_o        (pin_ctrl_o),
		.pin_sample_o      (pin_sample)
	);

	reg_readback #(.ROUTE_BYTES(ROUTE_BYTES)) u_readback (
		.clk          (clk),
		.reset        (reset),
		.cfg          (cfg_if.user),
		.rd_sel_i     (rd_sel),
		.rd_en_i      (rd_en),
		.rd_byte_i    (rd_byte),
		.pin_sample_i (pin_sample),
		.reg_datao_o  (reg_datao_o)
	);

endmodule

`default_nettype wire

//--- test/cw_io_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cw_io_assert (
	input wire       clk,
	input wire       reset,
	input wire       addrvalid_i,
	input wire [7:0] datao_i,
	input wire [3:0] pin_oe_i,
	input wire       power_off_i,
	input wire       trig_i,
	input wire [7:0] trigmod_i
);
	int fail_cnt = 0; // failed assertions so far

	// unpowered target never sees a driven pin
	a_power_off_hiz: assert property (@(posedge clk) disable iff (reset)
		power_off_i |-> (pin_oe_i == 4'h0))
		else begin
			fail_cnt++;
			$error("pin enable high while target power is off");
		end

	a_idle_read_zero: assert property (@(posedge clk) disable iff (reset)
		!addrvalid_i |=> (datao_i == 8'h00)) // read bus released after idle cycle
		else begin
			fail_cnt++;
			$error("read data not zero after a cycle without addrvalid");
		end

	a_unused_module_off: assert property (@(posedge clk) disable iff (reset)
		(trigmod_i[2:0] > 3'd4) |-> !trig_i) // codes 5..7 select nothing
		else begin
			fail_cnt++;
			$error("trigger high with an unused trigger module code");
		end

endmodule

bind cw_io_top cw_io_assert u_assert (
	.clk         (clk),
	.reset       (reset),
	.addrvalid_i (reg_addrvalid_i),
	.datao_i     (reg_datao_o),
	.pin_oe_i    (pin_oe_o),
	.power_off_i (targetpower_off_o),
	.trig_i      (trig_o),
	.trigmod_i   (cfg_if.trigmod)
);

`default_nettype wire

//--- test/cw_io_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cw_io_tb;
	import cw_io_pkg::*;

	localparam int ROUTE_BYTES = 8;
	localparam int CLK_PERIOD  = 4;
	localparam int NUM_TESTS   = 5;
	localparam int TEST_CYCLES = 200; // budget per directed test

	logic       clk = 1'b0;
	logic       reset;
	reg_addr_t  reg_addr;
	byte_cnt_t  reg_bytecnt;
	reg_byte_t  reg_datai;
	reg_byte_t  reg_datao;
	logic       reg_read;
	logic       reg_write;
	logic       reg_addrvalid;
	trig_src_t  trig_in;
	trig_mod_t  trig_module;
	logic       trig_ext;
	logic       trig_out;
	logic       trig_fpa_oe;
	pin_vec_t   pin_in;
	pin_vec_t   pin_out;
	pin_vec_t   pin_oe;
	logic       uart_tx;
	logic       usi_out;
	logic       uart_rx;
	logic       usi_in;
	logic       tpwr_off;
	logic       avrprog_en;
	logic [2:0] pin_ctrl_en;
	logic [2:0] pin_ctrl;

	logic [31:0] lfsr_q = 32'd70262;
	reg_byte_t   exp_trigsrc;            // shadow of the register bank
	reg_byte_t   exp_trigmod;
	reg_byte_t   exp_route [ROUTE_BYTES];

	cw_io_top #(.ROUTE_BYTES(ROUTE_BYTES)) DUT (
		.clk (clk), .reset (reset),
		.reg_addr_i (reg_addr), .reg_bytecnt_i (reg_bytecnt),
		.reg_datai_i (reg_datai), .reg_datao_o (reg_datao),
		.reg_read_i (reg_read), .reg_write_i (reg_write), .reg_addrvalid_i (reg_addrvalid),
		.trig_in_i (trig_in), .trig_module_i (trig_module),
		.trig_ext_o (trig_ext), .trig_o (trig_out), .trig_fpa_oe_o (trig_fpa_oe),
		.pin_in_i (pin_in), .pin_o (pin_out), .pin_oe_o (pin_oe),
		.uart_tx_i (uart_tx), .usi_out_i (usi_out), .uart_rx_o (uart_rx), .usi_in_o (usi_in),
		.targetpower_off_o (tpwr_off), .avrprog_en_o (avrprog_en),
		.pin_ctrl_en_o (pin_ctrl_en), .pin_ctrl_o (pin_ctrl)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// taps for x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[30:0], lfsr_q[0]}; // one step per bit taken
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("error %s expected %0h actual %0h", name, exp_v, act_v);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic bus_write(input reg_addr_t addr, input int cnt, input reg_byte_t data);
		@(posedge clk);
		reg_addr      <= addr;
		reg_bytecnt   <= byte_cnt_t'(cnt);
		reg_datai     <= data;
		reg_write     <= 1'b1;
		reg_addrvalid <= 1'b1;
		@(posedge clk); // write edge
		reg_write     <= 1'b0;
		reg_addrvalid <= 1'b0;
		if (addr == 6'd39) exp_trigsrc = data;
		if (addr == 6'd40) exp_trigmod = data;
		if (addr == 6'd55 && cnt < ROUTE_BYTES) exp_route[cnt] = data;
	endtask

	task automatic read_expect(input string name, input reg_addr_t addr, input int cnt,
			input reg_byte_t exp_v);
		@(posedge clk);
		reg_addr      <= addr;
		reg_bytecnt   <= byte_cnt_t'(cnt);
		reg_read      <= 1'b1;
		reg_addrvalid <= 1'b1;
		@(posedge clk); // data and valid flag load here
		reg_read      <= 1'b0;
		reg_addrvalid <= 1'b0;
		@(negedge clk);
		check_value(name, exp_v, reg_datao);
	endtask

	// external trigger from the enabled sources in the selected mode
	function automatic logic ext_model(input reg_byte_t src, input trig_src_t in_v);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (src[i]) begin
				any_hi = any_hi | in_v[i];
				all_hi = all_hi & in_v[i];
			end
		end
		case (src[7:6])
			2'd0:    return any_hi;
			2'd1:    return all_hi;
			2'd2:    return !all_hi;
			default: return 1'b0;
		endcase
	endfunction

	// tx, then usi out (pins 1-3), then oc usi / oc tx (pin 3), then gpio
	task automatic pin_model(input int p, input reg_byte_t rt, output logic val,
			output logic oe);
		val = 1'b0;
		oe  = 1'b0;
		if (rt[0]) begin
			val = uart_tx;
			oe  = 1'b1;
		end else if (p != 3 && rt[2]) begin
			val = usi_out;
			oe  = 1'b1;
		end else if (p == 2 && rt[4]) begin
			oe = !usi_out; // only pulls low
		end else if (p == 2 && rt[5]) begin
			oe = !uart_tx;
		end else if (rt[7]) begin
			val = rt[6];
			oe  = 1'b1;
		end
	endtask

	task automatic check_pins(input string name);
		pin_vec_t ev;
		pin_vec_t eo;
		for (int p = 0; p < 4; p++) begin
			pin_model(p, exp_route[p], ev[p], eo[p]);
		end
		check_value({name, "_oe"}, eo, pin_oe);
		check_value({name, "_val"}, ev & eo, pin_out & eo); // value only where driven
	endtask

	task automatic sweep_sources(input string name);
		for (int k = 0; k < 4; k++) begin
			@(posedge clk);
			uart_tx <= k[0];
			usi_out <= k[1];
			@(negedge clk);
			check_pins($sformatf("%s_%0d", name, k));
		end
	endtask

	// lowest marked pin wins and the line idles high when none is marked
	function automatic logic line_model(input int bitpos, input int npins, input pin_vec_t in_v);
		for (int p = 0; p < npins; p++) begin
			if (exp_route[p][bitpos]) return in_v[p];
		end
		return 1'b1;
	endfunction

	task automatic check_rx_lines(input string name);
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			rand_bits(4, r);
			@(posedge clk);
			// all low, then pin 2 alone high, then random patterns
			pin_in <= (i == 0) ? 4'h0 : (i == 1) ? 4'h2 : r[3:0];
			@(negedge clk);
			check_value({name, "_uart_rx"}, line_model(1, 4, pin_in), uart_rx);
			check_value({name, "_usi_in"}, line_model(3, 3, pin_in), usi_in);
		end
	endtask

	task automatic reset_values();
		@(negedge clk);
		check_value("reset_idle_bus", 8'h00, reg_datao);
		check_value("reset_power_off", 1'b0, tpwr_off);
		read_expect("reset_trigsrc", ADDR_TRIGSRC, 0, 8'h01);
		read_expect("reset_trigmod", ADDR_TRIGMOD, 0, 8'h00);
		for (int b = 0; b < ROUTE_BYTES; b++) begin
			read_expect($sformatf("reset_route%0d", b), ADDR_IOROUTE, b, exp_route[b]);
		end
		read_expect("reset_pin_sample", ADDR_IOREAD, 0, 8'h00);
		read_expect("reset_unknown_addr", 6'd12, 0, 8'h00);
	endtask

	task automatic write_readback();
		logic [31:0] r;
		logic [2:0]  ctl_en;
		logic [2:0]  ctl_val;
		rand_bits(8, r);
		bus_write(ADDR_TRIGSRC, 0, r[7:0]);
		rand_bits(8, r);
		bus_write(ADDR_TRIGMOD, 0, r[7:0]);
		for (int b = 0; b < ROUTE_BYTES; b++) begin
			rand_bits(8, r);
			if (b == 5) r[1] = 1'b0; // keep target powered
			bus_write(ADDR_IOROUTE, b, r[7:0]);
		end
		read_expect("wr_trigsrc", ADDR_TRIGSRC, 0, exp_trigsrc);
		read_expect("wr_trigmod", ADDR_TRIGMOD, 0, exp_trigmod);
		for (int b = 0; b < ROUTE_BYTES; b++) begin
			read_expect($sformatf("wr_route%0d", b), ADDR_IOROUTE, b, exp_route[b]);
		end
		for (int k = 0; k < 3; k++) begin
			ctl_en[k]  = exp_route[6][2*k];   // enable leads each nrst/pdid/pdic pair
			ctl_val[k] = exp_route[6][2*k+1];
		end
		check_value("wr_pin_ctrl_en", ctl_en, pin_ctrl_en);
		check_value("wr_pin_ctrl", ctl_val, pin_ctrl);
		bus_write(ADDR_IOREAD, 0, 8'hff); // write to a read-only register is dropped
		read_expect("wr_ioread_ignored", ADDR_IOREAD, 0, 8'h00);
		read_expect("wr_trigsrc_kept", ADDR_TRIGSRC, 0, exp_trigsrc);
	endtask

	task automatic trigger_modes();
		logic [31:0] r;
		logic        exp_t;
		for (int mode = 0; mode < 4; mode++) begin
			rand_bits(6, r);
			bus_write(ADDR_TRIGSRC, 0, {mode[1:0], r[5:0]});
			for (int code = 0; code < 8; code++) begin
				rand_bits(1, r);
				bus_write(ADDR_TRIGMOD, 0, {4'h0, r[0], code[2:0]});
				repeat (2) begin
					rand_bits(10, r);
					@(posedge clk);
					trig_in     <= r[5:0];
					trig_module <= r[9:6];
					@(negedge clk);
					if (code == 0) exp_t = ext_model(exp_trigsrc, trig_in);
					else if (code <= 4) exp_t = trig_module[code-1];
					else exp_t = 1'b0;
					check_value("trig_ext", ext_model(exp_trigsrc, trig_in), trig_ext);
					check_value($sformatf("trig_code%0d", code), exp_t, trig_out);
					check_value("trig_fpa_oe", exp_trigmod[3], trig_fpa_oe);
				end
			end
		end
	endtask

	task automatic pin_routing();
		bus_write(ADDR_IOROUTE, 0, 8'hc5); // tx over usi and gpio
		bus_write(ADDR_IOROUTE, 1, 8'h84); // usi over gpio
		bus_write(ADDR_IOROUTE, 2, 8'hb0); // oc usi over oc tx and gpio
		bus_write(ADDR_IOROUTE, 3, 8'hc4); // pin 4 ignores usi and drives gpio high
		sweep_sources("route_a");
		bus_write(ADDR_IOROUTE, 0, 8'h80); // gpio low
		bus_write(ADDR_IOROUTE, 1, 8'h00); // undriven
		bus_write(ADDR_IOROUTE, 2, 8'he0); // oc tx over gpio
		bus_write(ADDR_IOROUTE, 3, 8'h01);
		sweep_sources("route_b");
		bus_write(ADDR_IOROUTE, 0, 8'h00);
		bus_write(ADDR_IOROUTE, 1, 8'h0a); // rx and usi in on pins 2..4
		bus_write(ADDR_IOROUTE, 2, 8'h0a);
		bus_write(ADDR_IOROUTE, 3, 8'h0a);
		check_rx_lines("rx_lowest");
		bus_write(ADDR_IOROUTE, 1, 8'h00);
		bus_write(ADDR_IOROUTE, 2, 8'h00);
		bus_write(ADDR_IOROUTE, 3, 8'h08); // usi in on pin 4 is not a usi pin
		check_rx_lines("rx_default");
	endtask

	task automatic power_off_sample();
		logic [31:0] r;
		bus_write(ADDR_IOROUTE, 0, 8'h01);
		bus_write(ADDR_IOROUTE, 1, 8'h80);
		bus_write(ADDR_IOROUTE, 2, 8'h84);
		bus_write(ADDR_IOROUTE, 3, 8'h80);
		sweep_sources("power_on");
		bus_write(ADDR_IOROUTE, 5, 8'h02); // power off, avrprog off
		@(negedge clk);
		check_value("power_off_delay", 1'b0, tpwr_off); // registered one clock later
		@(negedge clk);
		check_value("power_off_set", 1'b1, tpwr_off);
		check_value("power_off_hiz", 4'h0, pin_oe);
		check_value("avrprog_off", 1'b0, avrprog_en);
		bus_write(ADDR_IOROUTE, 5, 8'h01); // power back, avrprog on
		repeat (2) @(negedge clk);
		check_value("power_restored", 1'b0, tpwr_off);
		check_value("avrprog_on", 1'b1, avrprog_en);
		sweep_sources("power_back");
		for (int i = 0; i < 4; i++) begin
			rand_bits(4, r);
			@(posedge clk);
			pin_in <= r[3:0];
			read_expect($sformatf("pin_sample%0d", i), ADDR_IOREAD, 0, {4'h0, r[3:0]});
		end
	endtask

	initial begin : watchdog
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("timeout, the run hung before the tests finished");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		reset         = 1'b1;
		reg_addr      = '0;
		reg_bytecnt   = '0;
		reg_datai     = '0;
		reg_read      = 1'b0;
		reg_write     = 1'b0;
		reg_addrvalid = 1'b0;
		trig_in       = '0;
		trig_module   = '0;
		pin_in        = '0;
		uart_tx       = 1'b1; // uart idle high
		usi_out       = 1'b1;
		exp_trigsrc   = 8'h01;
		exp_trigmod   = 8'h00;
		for (int b = 0; b < ROUTE_BYTES; b++) begin
			exp_route[b] = 8'h00;
		end
		exp_route[0] = 8'h01;
		exp_route[1] = 8'h02;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		reset_values();
		write_readback();
		trigger_modes();
		pin_routing();
		power_off_sample();
		repeat (2) @(posedge clk);
		if (DUT.u_assert.fail_cnt != 0) begin
			$display("%0d assertion failures during the run", DUT.u_assert.fail_cnt);
			$display("TEST FAILED");
			$fatal(1, "assertions failed");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- cw_io.f
hw/cw_io_pkg.sv
hw/cw_config_if.sv
hw/reg_access_decode.sv
hw/trigger_combine.sv
hw/target_io_route.sv
hw/reg_readback.sv
hw/cw_io_top.sv
test/cw_io_assert.sv
test/cw_io_tb.sv

//--- Bender.yml
package:
  name: cw_io

sources:
  - hw/cw_io_pkg.sv
  - hw/cw_config_if.sv
  - hw/reg_access_decode.sv
  - hw/trigger_combine.sv
  - hw/target_io_route.sv
  - hw/reg_readback.sv
  - hw/cw_io_top.sv
  - target: test
    files:
      - test/cw_io_assert.sv
      - test/cw_io_tb.sv
